/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing
TOP        := tb_floor_controller
RTL_TOP    := floor_controller
FILELIST   := project.f
MDIR       := obj_dir
LOG        := sim.log
PASS_TEXT  := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(MDIR)

run: build
	./$(MDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(MDIR) $(LOG)

/* project.f */
rtl/floor_pkg.sv
rtl/car_pkg.sv
rtl/request_latch.sv
rtl/request_queue.sv
rtl/dispatch_control.sv
rtl/floor_controller.sv
test/tb_floor_controller.sv

/* rtl/car_pkg.sv */
// Car motion comes from an external motor controller that only reports stopped, up or down
`default_nettype none

package car_pkg;

    // Motion as reported by the motor controller
    typedef enum logic [1:0] {
        car_stopped = 2'd0,
        car_up      = 2'd1,
        car_down    = 2'd2
    } car_state_t;

    // Dispatch sequence of the request controller
    typedef enum logic [1:0] {
        disp_idle   = 2'd0,  // waiting for a queued floor
        disp_depart = 2'd1,  // target loaded and motor asked to start
        disp_travel = 2'd2,  // car on its way to the target
        disp_halted = 2'd3   // power off or emergency
    } dispatch_state_t;

endpackage

`default_nettype wire

/* rtl/dispatch_control.sv */
// Serves one floor at a time in queue order and relies on the motor controller to report stops
`default_nettype none
`timescale 1ns/1ns

module dispatch_control (
    input  wire                        clock,
    input  wire                        reset_n,
    input  wire                        emergency_btn,
    input  wire                        power_switch,
    input  wire  car_pkg::car_state_t  car_state,
    input  wire  floor_pkg::floor_t    current_floor,
    input  wire  floor_pkg::floor_t    head_floor,
    input  wire                        queue_empty,
    input  wire                        door_open_btn,
    input  wire                        door_close_btn,
    output logic                       pop,
    output logic                       arrive,
    output logic                       flush,
    output floor_pkg::floor_t          elevator_floor_selector,
    output logic                       direction_selector,
    output logic                       activate_elevator,
    output logic                       door_open_allowed,
    output logic                       door_close_allowed
);

    car_pkg::dispatch_state_t state;
    car_pkg::dispatch_state_t state_next;
    logic                     stopped;
    logic                     at_target;
    logic                     arrived;

    // Power loss or emergency drops every pending request
    assign flush = !power_switch || emergency_btn;

    assign stopped   = (car_state == car_pkg::car_stopped);
    assign at_target = stopped && (current_floor == elevator_floor_selector);

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        pop        = 1'b0;
        arrived    = 1'b0;
        if (flush) begin
            state_next = car_pkg::disp_halted;
        end else begin
            case (state)
                car_pkg::disp_idle: begin
                    // Head is taken at the same edge the target loads
                    if (!queue_empty && stopped) begin
                        pop        = 1'b1;
                        state_next = car_pkg::disp_depart;
                    end
                end
                car_pkg::disp_depart: begin
                    // Target may already be the floor the car sits at
                    if (at_target) begin
                        arrived    = 1'b1;
                        state_next = car_pkg::disp_idle;
                    end else if (!stopped) begin
                        state_next = car_pkg::disp_travel;
                    end
                end
                car_pkg::disp_travel: begin
                    if (at_target) begin
                        arrived    = 1'b1;
                        state_next = car_pkg::disp_idle;
                    end
                end
                car_pkg::disp_halted: begin
                    state_next = car_pkg::disp_idle;
                end
                default: begin
                    state_next = car_pkg::disp_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // State, target and arrival strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state                   <= car_pkg::disp_idle;
            arrive                  <= 1'b0;
            elevator_floor_selector <= floor_pkg::LOWEST_FLOOR;
            direction_selector      <= 1'b0;
        end else begin
            state  <= state_next;
            arrive <= arrived;
            // Target holds through a halt
            if (pop) begin
                elevator_floor_selector <= head_floor;
                direction_selector      <= (head_floor > current_floor);
            end
        end
    end

    assign activate_elevator = (state == car_pkg::disp_depart);

    // Doors only answer a stopped, powered car
    assign door_open_allowed  = door_open_btn && stopped && power_switch;
    assign door_close_allowed = door_close_btn && stopped && power_switch;

endmodule

`default_nettype wire

/* rtl/floor_controller.sv */
// Floor count must stay between 2 and 16 and the car must report its floor on current_floor
`default_nettype none
`timescale 1ns/1ns

module floor_controller #(
    parameter int FLOOR_COUNT = floor_pkg::DEFAULT_FLOORS,
    // One slot per floor is enough since a lit floor is never queued again
    parameter int QUEUE_DEPTH = floor_pkg::DEFAULT_FLOORS
) (
    input  wire                        clock,
    input  wire                        reset_n,
    input  wire  [FLOOR_COUNT-1:0]     floor_call_buttons,
    input  wire  [FLOOR_COUNT-1:0]     panel_buttons,
    input  wire                        door_open_btn,
    input  wire                        door_close_btn,
    input  wire                        emergency_btn,
    input  wire                        power_switch,
    input  wire  floor_pkg::floor_t    current_floor,
    input  wire  car_pkg::car_state_t  car_state,
    output floor_pkg::floor_t          elevator_floor_selector,
    output logic                       direction_selector,
    output logic                       activate_elevator,
    output logic [FLOOR_COUNT-1:0]     call_button_lights,
    output logic [FLOOR_COUNT-1:0]     panel_button_lights,
    output logic                       door_open_allowed,
    output logic                       door_close_allowed
);

    // Request path
    logic              new_request;
    floor_pkg::floor_t new_floor;

    // Queue status
    floor_pkg::floor_t head_floor;
    logic              queue_empty;
    logic              queue_full;

    // Control strobes
    logic              pop;
    logic              arrive;
    logic              flush;

    request_latch #(
        .FLOOR_COUNT(FLOOR_COUNT)
    ) u_request_latch (
        .clock              (clock),
        .reset_n            (reset_n),
        .floor_call_buttons (floor_call_buttons),
        .panel_buttons      (panel_buttons),
        .current_floor      (current_floor),
        .queue_full         (queue_full),
        .flush              (flush),
        .arrive             (arrive),
        .call_button_lights (call_button_lights),
        .panel_button_lights(panel_button_lights),
        .new_request        (new_request),
        .new_floor          (new_floor)
    );

    request_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_request_queue (
        .clock      (clock),
        .reset_n    (reset_n),
        .new_request(new_request),
        .new_floor  (new_floor),
        .pop        (pop),
        .flush      (flush),
        .head_floor (head_floor),
        .queue_empty(queue_empty),
        .queue_full (queue_full)
    );

    dispatch_control u_dispatch_control (
        .clock                  (clock),
        .reset_n                (reset_n),
        .emergency_btn          (emergency_btn),
        .power_switch           (power_switch),
        .car_state              (car_state),
        .current_floor          (current_floor),
        .head_floor             (head_floor),
        .queue_empty            (queue_empty),
        .door_open_btn          (door_open_btn),
        .door_close_btn         (door_close_btn),
        .pop                    (pop),
        .arrive                 (arrive),
        .flush                  (flush),
        .elevator_floor_selector(elevator_floor_selector),
        .direction_selector     (direction_selector),
        .activate_elevator      (activate_elevator),
        .door_open_allowed      (door_open_allowed),
        .door_close_allowed     (door_close_allowed)
    );

endmodule

`default_nettype wire

/* rtl/floor_pkg.sv */
// Floor 0 is the lowest landing and a 4-bit floor number caps the car at 16 floors
`default_nettype none

package floor_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Floor numbering
    ////////////////////////////////////////////////////////////////////////////

    // Width of every floor number on the ports
    localparam int FLOOR_BITS = 4;

    // Landings in the target building
    localparam int DEFAULT_FLOORS = 11;

    typedef logic [FLOOR_BITS-1:0] floor_t;

    // Car parks here out of reset
    localparam floor_t LOWEST_FLOOR = '0;

endpackage

`default_nettype wire

/* rtl/request_latch.sv */
// Buttons are levels sampled on each rising edge and at most one request is taken per edge
`default_nettype none
`timescale 1ns/1ns

module request_latch #(
    parameter int FLOOR_COUNT = floor_pkg::DEFAULT_FLOORS
) (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire  [FLOOR_COUNT-1:0]       floor_call_buttons,
    input  wire  [FLOOR_COUNT-1:0]       panel_buttons,
    input  wire  floor_pkg::floor_t      current_floor,
    input  wire                          queue_full,
    input  wire                          flush,
    input  wire                          arrive,
    output logic [FLOOR_COUNT-1:0]       call_button_lights,
    output logic [FLOOR_COUNT-1:0]       panel_button_lights,
    output logic                         new_request,
    output floor_pkg::floor_t            new_floor
);

    logic [FLOOR_COUNT-1:0] lit;
    logic [FLOOR_COUNT-1:0] at_floor;
    logic [FLOOR_COUNT-1:0] panel_ok;
    logic [FLOOR_COUNT-1:0] call_ok;
    logic [FLOOR_COUNT-1:0] win;
    logic                   found;
    logic                   from_panel;
    logic [FLOOR_COUNT-1:0] panel_set;
    logic [FLOOR_COUNT-1:0] call_set;
    logic [FLOOR_COUNT-1:0] clear_mask;

    assign lit = call_button_lights | panel_button_lights;

    // One-hot position of the car
    always_comb begin
        for (int i = 0; i < FLOOR_COUNT; i++) begin
            at_floor[i] = (current_floor == floor_pkg::floor_t'(i));
        end
    end

    // A lit floor is never queued twice, whichever button lit it
    assign panel_ok = panel_buttons & ~at_floor & ~lit;
    assign call_ok  = floor_call_buttons & ~at_floor & ~lit;

    ////////////////////////////////////////////////////////////////////////////
    // Fixed priority pick
    ////////////////////////////////////////////////////////////////////////////

    // Panel before call, lower floor first
    always_comb begin
        found      = 1'b0;
        from_panel = 1'b0;
        win        = '0;
        new_floor  = floor_pkg::LOWEST_FLOOR;
        for (int i = 0; i < FLOOR_COUNT; i++) begin
            if (!found && panel_ok[i]) begin
                found      = 1'b1;
                from_panel = 1'b1;
                win[i]     = 1'b1;
                new_floor  = floor_pkg::floor_t'(i);
            end
        end
        for (int i = 0; i < FLOOR_COUNT; i++) begin
            if (!found && call_ok[i]) begin
                found     = 1'b1;
                win[i]    = 1'b1;
                new_floor = floor_pkg::floor_t'(i);
            end
        end
    end

    assign new_request = found && !queue_full && !flush;

    assign panel_set  = (new_request && from_panel) ? win : '0;
    assign call_set   = (new_request && !from_panel) ? win : '0;
    assign clear_mask = arrive ? at_floor : '0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else if (flush) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            // Set and clear never hit the same floor since the winner is never here
            panel_button_lights <= (panel_button_lights & ~clear_mask) | panel_set;
            call_button_lights  <= (call_button_lights & ~clear_mask) | call_set;
        end
    end

endmodule

`default_nettype wire

/* rtl/request_queue.sv */
// Push while full is not guarded here because the request latch stops pushing at full
`default_nettype none
`timescale 1ns/1ns

module request_queue #(
    parameter int QUEUE_DEPTH = floor_pkg::DEFAULT_FLOORS
) (
    input  wire                      clock,
    input  wire                      reset_n,
    input  wire                      new_request,
    input  wire  floor_pkg::floor_t  new_floor,
    input  wire                      pop,
    input  wire                      flush,
    output floor_pkg::floor_t        head_floor,
    output logic                     queue_empty,
    output logic                     queue_full
);

    localparam int PTR_BITS   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(QUEUE_DEPTH + 1);

    floor_pkg::floor_t     slots [QUEUE_DEPTH];
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [COUNT_BITS-1:0] count;
    logic                  do_pop;

    // Circular step that wraps at the last slot
    function automatic logic [PTR_BITS-1:0] advance(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_pop = pop && !queue_empty;

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (new_request) begin
            slots[wr_ptr] <= new_floor;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (new_request) begin
                wr_ptr <= advance(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= advance(rd_ptr);
            end
            // Push and pop together leave the count alone
            case ({new_request, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_floor  = slots[rd_ptr];
    assign queue_empty = (count == '0);
    assign queue_full  = (count == COUNT_BITS'(QUEUE_DEPTH));

endmodule

`default_nettype wire

/* test/tb_floor_controller.sv */
// Car model moves one floor per 3 cycles and stops only at the dispatched target floor
`default_nettype none
`timescale 1ns/1ns

module tb_floor_controller;

    localparam int FLOOR_COUNT  = floor_pkg::DEFAULT_FLOORS;
    localparam int SEED         = 75454;
    localparam int TRAVEL_LIMIT = 80;
    localparam int QUIET_CYCLES = 30;

    logic                   clock;
    logic                   reset_n;
    logic [FLOOR_COUNT-1:0] floor_call_buttons;
    logic [FLOOR_COUNT-1:0] panel_buttons;
    logic                   door_open_btn;
    logic                   door_close_btn;
    logic                   emergency_btn;
    logic                   power_switch;
    floor_pkg::floor_t      current_floor;
    car_pkg::car_state_t    car_state;
    floor_pkg::floor_t      elevator_floor_selector;
    logic                   direction_selector;
    logic                   activate_elevator;
    logic [FLOOR_COUNT-1:0] call_button_lights;
    logic [FLOOR_COUNT-1:0] panel_button_lights;
    logic                   door_open_allowed;
    logic                   door_close_allowed;

    // Bookkeeping
    string             test_name;
    int                error_count;
    int                test_errors;
    int                tests_run;
    int                tests_failed;
    int                step_count;
    bit                prev_active;
    floor_pkg::floor_t disp_floor [$];
    bit                disp_up [$];
    floor_pkg::floor_t target;

    floor_controller #(
        .FLOOR_COUNT(FLOOR_COUNT),
        .QUEUE_DEPTH(FLOOR_COUNT)
    ) uut (
        .clock                  (clock),
        .reset_n                (reset_n),
        .floor_call_buttons     (floor_call_buttons),
        .panel_buttons          (panel_buttons),
        .door_open_btn          (door_open_btn),
        .door_close_btn         (door_close_btn),
        .emergency_btn          (emergency_btn),
        .power_switch           (power_switch),
        .current_floor          (current_floor),
        .car_state              (car_state),
        .elevator_floor_selector(elevator_floor_selector),
        .direction_selector     (direction_selector),
        .activate_elevator      (activate_elevator),
        .call_button_lights     (call_button_lights),
        .panel_button_lights    (panel_button_lights),
        .door_open_allowed      (door_open_allowed),
        .door_close_allowed     (door_close_allowed)
    );

    always #50 clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("[FAIL] %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d error(s)", test_name, test_errors);
            tests_failed++;
        end
        tests_run++;
        test_errors = 0;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout in test %s while waiting for %s", test_name, what);
        $display("Finished with errors");
        $finish;
    endtask

    // Motor controller stand-in that runs once per falling edge
    task automatic move_car();
        if (car_state == car_pkg::car_stopped) begin
            if (activate_elevator && current_floor != elevator_floor_selector) begin
                car_state  = direction_selector ? car_pkg::car_up : car_pkg::car_down;
                step_count = 0;
            end
        end else begin
            step_count++;
            if (step_count == 3) begin
                step_count = 0;
                if (car_state == car_pkg::car_up) begin
                    current_floor = current_floor + 1'b1;
                end else begin
                    current_floor = current_floor - 1'b1;
                end
                if (current_floor == elevator_floor_selector) begin
                    car_state = car_pkg::car_stopped;
                end
            end
        end
    endtask

    // Advance to the next falling edge, log dispatches, then move the car
    task automatic next_cycle();
        @(negedge clock);
        if (activate_elevator && !prev_active) begin
            disp_floor.push_back(elevator_floor_selector);
            disp_up.push_back(direction_selector);
        end
        prev_active = activate_elevator;
        move_car();
    endtask

    task automatic wait_for_stop_at(input floor_pkg::floor_t floor);
        int waited;
        waited = 0;
        while (!(car_state == car_pkg::car_stopped && current_floor == floor)
               && waited < TRAVEL_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!(car_state == car_pkg::car_stopped && current_floor == floor)) begin
            abort_on_timeout("the car to stop at its target");
        end
    endtask

    task automatic check_halt(input bit by_power);
        int logged;
        next_cycle();
        panel_buttons[1]      = 1'b1;
        floor_call_buttons[3] = 1'b1;
        next_cycle();
        panel_buttons = '0;
        check_value("panel light 1 pending", 1, int'(panel_button_lights[1]));
        if (by_power) begin
            power_switch = 1'b0;
        end else begin
            emergency_btn = 1'b1;
        end
        next_cycle();
        check_value("call lights", 0, int'(call_button_lights));
        check_value("panel lights", 0, int'(panel_button_lights));
        check_value("activate_elevator", 0, int'(activate_elevator));
        power_switch       = 1'b1;
        emergency_btn      = 1'b0;
        floor_call_buttons = '0;
        logged = disp_floor.size();
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            next_cycle();
        end
        check_value("dispatches after release", logged, disp_floor.size());
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        clock              = 1'b0;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        current_floor      = floor_pkg::LOWEST_FLOOR;
        car_state          = car_pkg::car_stopped;
        error_count        = 0;
        test_errors        = 0;
        tests_run          = 0;
        tests_failed       = 0;
        step_count         = 0;
        prev_active        = 1'b0;

        test_name = "reset";
        repeat (8) next_cycle();
        reset_n = 1'b1;
        next_cycle();
        check_value("call lights", 0, int'(call_button_lights));
        check_value("panel lights", 0, int'(panel_button_lights));
        check_value("activate_elevator", 0, int'(activate_elevator));
        check_value("direction_selector", 0, int'(direction_selector));
        check_value("door_open_allowed", 0, int'(door_open_allowed));
        check_value("door_close_allowed", 0, int'(door_close_allowed));
        check_value("selector", 0, int'(elevator_floor_selector));
        finish_test();

        test_name = "request_dispatch";
        target = floor_pkg::floor_t'(1 + ($urandom % 10));
        panel_buttons[target] = 1'b1;
        next_cycle();
        panel_buttons = '0;
        check_value("panel light", 1, int'(panel_button_lights[target]));
        next_cycle();
        check_value("activate_elevator", 1, int'(activate_elevator));
        check_value("selector", int'(target), int'(elevator_floor_selector));
        check_value("direction_selector", 1, int'(direction_selector));
        finish_test();

        test_name = "arrival";
        wait_for_stop_at(target);
        next_cycle();
        next_cycle();
        check_value("panel light", 0, int'(panel_button_lights[target]));
        check_value("call light", 0, int'(call_button_lights[target]));
        check_value("activate_elevator", 0, int'(activate_elevator));
        finish_test();

        test_name = "order_duplicates";
        current_floor = floor_pkg::floor_t'(4);
        next_cycle();
        next_cycle();
        disp_floor.delete();
        disp_up.delete();
        floor_call_buttons[2] = 1'b1;
        next_cycle();
        floor_call_buttons = '0;
        check_value("call light 2", 1, int'(call_button_lights[2]));
        panel_buttons[8]   = 1'b1;
        next_cycle();
        panel_buttons         = '0;
        floor_call_buttons[8] = 1'b1;
        next_cycle();
        floor_call_buttons = '0;
        panel_buttons[4]   = 1'b1;
        next_cycle();
        panel_buttons = '0;
        check_value("call light 8", 0, int'(call_button_lights[8]));
        check_value("panel light 4", 0, int'(panel_button_lights[4]));
        wait_for_stop_at(floor_pkg::floor_t'(2));
        wait_for_stop_at(floor_pkg::floor_t'(8));
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            next_cycle();
        end
        check_value("dispatch count", 2, disp_floor.size());
        if (disp_floor.size() == 2) begin
            check_value("first floor", 2, int'(disp_floor[0]));
            check_value("first direction", 0, int'(disp_up[0]));
            check_value("second floor", 8, int'(disp_floor[1]));
            check_value("second direction", 1, int'(disp_up[1]));
        end
        finish_test();

        test_name = "halt_emergency";
        check_halt(1'b0);
        finish_test();

        test_name = "halt_power";
        check_halt(1'b1);
        finish_test();

        test_name = "doors";
        door_open_btn = 1'b1;
        next_cycle();
        check_value("open permit", 1, int'(door_open_allowed));
        check_value("close permit", 0, int'(door_close_allowed));
        door_open_btn  = 1'b0;
        door_close_btn = 1'b1;
        next_cycle();
        check_value("open permit", 0, int'(door_open_allowed));
        check_value("close permit", 1, int'(door_close_allowed));
        // Car reported moving while both buttons are held
        door_open_btn = 1'b1;
        car_state     = car_pkg::car_up;
        next_cycle();
        check_value("open permit moving", 0, int'(door_open_allowed));
        check_value("close permit moving", 0, int'(door_close_allowed));
        car_state    = car_pkg::car_stopped;
        step_count   = 0;
        power_switch = 1'b0;
        next_cycle();
        check_value("open permit unpowered", 0, int'(door_open_allowed));
        check_value("close permit unpowered", 0, int'(door_close_allowed));
        power_switch   = 1'b1;
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
        next_cycle();
        finish_test();

        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
